//--- verilog.f
hdl/sifhPkg.sv
hdl/peakIf.sv
hdl/frameControl.sv
hdl/pixelCounter.sv
hdl/peakSearch.sv
hdl/thresholdCalc.sv
hdl/thresholdTable.sv
hdl/sifhTop.sv
dv/sifhChecker.sv
dv/sifhTb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= sifhTb
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
TIMESCALE ?= 1ns/10ps
VFLAGS    ?= --binary --timing -j 0
PASS_MSG  ?= Verification passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --timescale $(TIMESCALE) --top-module $(TOP) \
		--Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

//--- dv/sifhTb.sv
`timescale 1ns/10ps
`default_nettype none

module sifhTb;

    localparam int Nb = 4;
    localparam int Np = 8;
    localparam int Nc = 8;
    localparam int PixelNum = 8;
    localparam int Pw = 3;
    localparam int NBins = 1 << Nb;
    localparam int DoneTimeout = 20;  // cycles allowed after the last bin

    logic          clk;
    logic          res;
    logic          frameStart;
    logic          binValid;
    logic [Nc-1:0] binCount;
    logic [Pw-1:0] rdPixel;
    logic          readCheck;
    int            testId;
    wire           busy;
    wire           frameDone;
    wire  [Nb-1:0] rdPeak;
    wire  [Np-1:0] rdThMinus;
    wire  [Np-1:0] rdThPlus;
    wire  [Np-1:0] rdCenter;
    int            valueErrs;
    int            frameErrs;
    int            timeoutErrs;
    logic [31:0]   lfsr;
    int            counts [NBins];

    sifhTop #(.Nb(Nb), .Np(Np), .Nc(Nc), .PixelNum(PixelNum)) dut0 (
        .clk(clk), .res(res), .frameStart(frameStart), .binValid(binValid),
        .binCount(binCount), .rdPixel(rdPixel), .busy(busy), .frameDone(frameDone),
        .rdPeak(rdPeak), .rdThMinus(rdThMinus), .rdThPlus(rdThPlus), .rdCenter(rdCenter)
    );

    sifhChecker #(.Nb(Nb), .Np(Np), .Nc(Nc), .PixelNum(PixelNum)) chk0 (
        .clk(clk), .res(res), .frameStart(frameStart), .binValid(binValid),
        .binCount(binCount), .rdPixel(rdPixel), .readCheck(readCheck), .testId(testId),
        .busy(busy), .frameDone(frameDone), .rdPeak(rdPeak), .rdThMinus(rdThMinus),
        .rdThPlus(rdThPlus), .rdCenter(rdCenter), .valueErrs(valueErrs),
        .frameErrs(frameErrs)
    );

    always #4 clk = ~clk;

    // Galois LFSR stepped once per bit taken
    function automatic logic nextBit();
        nextBit = lfsr[0];
        lfsr = (lfsr >> 1) ^ (lfsr[0] ? 32'h8020_0003 : 32'h0);
    endfunction

    function automatic int randBits(int n);
        int v;
        int i;
        v = 0;
        for (i = 0; i < n; i++) v = (v << 1) | nextBit();
        return v;
    endfunction

    task automatic tick();
        @(posedge clk);
        #1;
    endtask

    // mode 0 random, 1 forced tie, 2 peak at bin 0 or 1, 3 peak at the top bin
    task automatic makeCounts(int mode);
        int b;
        int a;
        for (b = 0; b < NBins; b++) counts[b] = randBits(mode == 0 ? 8 : 6);
        case (mode)
            1: begin
                a = randBits(3);
                counts[a] = 200;
                counts[a + 1 + randBits(3)] = 200;  // later twin must lose
            end
            2: counts[randBits(1)] = 250;
            3: counts[NBins-1] = 250;
            default: ;
        endcase
    endtask

    task automatic runFrame(int mode, int gaps);
        int p;
        int b;
        int i;
        int gapLen;
        frameStart = 1'b1;
        tick();
        frameStart = 1'b0;
        for (p = 0; p < PixelNum; p++) begin
            makeCounts(mode);
            for (b = 0; b < NBins; b++) begin
                binValid = 1'b1;
                binCount = Nc'(counts[b]);
                tick();
                binValid = 1'b0;
                if (gaps != 0 && randBits(2) == 0) begin
                    gapLen = 1 + randBits(2);
                    for (i = 0; i < gapLen; i++) tick();
                end
            end
        end
        i = 0;
        while (!frameDone && i < DoneTimeout) begin
            tick();
            i++;
        end
        if (!frameDone) begin
            timeoutErrs++;
            $display("timeout: no frameDone within %0d cycles of the last bin", DoneTimeout);
        end
        tick();
    endtask

    task automatic readAll();
        int p;
        readCheck = 1'b1;
        for (p = 0; p < PixelNum; p++) begin
            rdPixel = Pw'(p);
            tick();
        end
        readCheck = 1'b0;
        tick();  // last read still being compared
    endtask

    initial begin
        clk = 1'b0;
        res = 1'b0;
        frameStart = 1'b0;
        binValid = 1'b0;
        binCount = '0;
        rdPixel = '0;
        readCheck = 1'b0;
        testId = 0;
        timeoutErrs = 0;
        lfsr = 32'h5bb8;
        repeat (2) @(posedge clk);
        #1 res = 1'b1;
        tick();
        readAll();
        testId = 1;
        repeat (4) begin
            runFrame(0, 0);
            readAll();
        end
        testId = 2;
        repeat (3) begin
            runFrame(1, 0);
            readAll();
        end
        testId = 3;
        repeat (2) begin
            runFrame(2, 0);
            readAll();
        end
        testId = 4;
        repeat (2) begin
            runFrame(3, 0);
            readAll();
        end
        testId = 5;
        repeat (2 * NBins) begin
            binValid = 1'b1;  // ignored while idle
            binCount = Nc'(randBits(8));
            tick();
            binValid = 1'b0;
            tick();
        end
        readAll();
        testId = 6;
        repeat (3) begin
            runFrame(0, 1);
            readAll();
        end
        $display("errors: %0d value, %0d framing, %0d timeout",
                 valueErrs, frameErrs, timeoutErrs);
        if (valueErrs + frameErrs + timeoutErrs == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- dv/sifhChecker.sv
`timescale 1ns/10ps
`default_nettype none

module sifhChecker #(
    parameter int Nb = 4,
    parameter int Np = 8,
    parameter int Nc = 8,
    parameter int PixelNum = 8,
    localparam int Pw = (PixelNum > 1) ? $clog2(PixelNum) : 1
) (
    input  wire          clk,
    input  wire          res,
    input  wire          frameStart,
    input  wire          binValid,
    input  wire [Nc-1:0] binCount,
    input  wire [Pw-1:0] rdPixel,
    input  wire          readCheck,
    input  int           testId,
    input  wire          busy,
    input  wire          frameDone,
    input  wire [Nb-1:0] rdPeak,
    input  wire [Np-1:0] rdThMinus,
    input  wire [Np-1:0] rdThPlus,
    input  wire [Np-1:0] rdCenter,
    output int           valueErrs,
    output int           frameErrs
);

    localparam int NBins = 1 << Nb;
    localparam int Sh = Np - Nb;          // log2 of the bin width
    localparam int Half = 3 << (Sh - 1);  // one and a half bins
    localparam int Full = (1 << Np) - 1;

    int binCounts [PixelNum*NBins];
    int expPeak [PixelNum];
    int expMinus [PixelNum];
    int expPlus [PixelNum];
    int binCnt;
    int doneWait;       // edges since the final bin
    logic mCollect;
    logic mBusy;
    logic mDone;
    logic armed;        // final bin seen, frameDone pending
    logic rdPend;
    logic [Pw-1:0] rdPrev;

    function automatic string testName(int id);
        case (id)
            0: return "reset";
            1: return "randomFrames";
            2: return "tieFrames";
            3: return "lowClamp";
            4: return "highClamp";
            5: return "idlePulses";
            6: return "gapFrames";
            default: return "unknown";
        endcase
    endfunction

    // highest count, earliest bin keeps a tie
    function automatic int findPeak(int p);
        int best;
        int b;
        best = 0;
        for (b = 1; b < NBins; b++) begin
            if (binCounts[p*NBins+b] > binCounts[p*NBins+best]) best = b;
        end
        return best;
    endfunction

    task automatic setBounds(int p);
        int ch;
        ch = expPeak[p] << Sh;
        if (ch >= Full - Half) begin
            expPlus[p]  = Full;
            expMinus[p] = Full - 2 * Half;
        end else if (ch <= Half) begin
            expPlus[p]  = 2 * Half;
            expMinus[p] = 0;
        end else begin
            expPlus[p]  = ch + Half;
            expMinus[p] = ch - Half;
        end
    endtask

    task automatic compareField(string field, int p, int exp, int act);
        if (exp != act) begin
            valueErrs++;
            $display("[ERROR] %s: %s of pixel %0d expected %0d actual %0d",
                     testName(testId), field, p, exp, act);
        end
    endtask

    task automatic frameError(string what);
        frameErrs++;
        $display("%s: %s", testName(testId), what);
    endtask

    always @(posedge clk or negedge res) begin
        int p;
        logic wasIdle;
        if (!res) begin
            for (p = 0; p < PixelNum; p++) begin
                expPeak[p]  = 0;  // table clears on reset
                expMinus[p] = 0;
                expPlus[p]  = 0;
            end
            {mCollect, mBusy, mDone, armed, rdPend} = '0;
            binCnt = 0;
            doneWait = 0;
            rdPrev = '0;
            valueErrs = 0;
            frameErrs = 0;
        end else begin
            if (busy !== mBusy) frameError("busy does not follow the frame state");
            if (frameDone !== mDone) frameError("frameDone missing or at the wrong time");
            if (rdPend) begin
                compareField("peak", rdPrev, expPeak[rdPrev], rdPeak);
                compareField("thMinus", rdPrev, expMinus[rdPrev], rdThMinus);
                compareField("thPlus", rdPrev, expPlus[rdPrev], rdThPlus);
                compareField("centre", rdPrev, (expMinus[rdPrev] + expPlus[rdPrev]) / 2,
                             rdCenter);
            end
            rdPend = readCheck;  // read data is due at the next edge
            rdPrev = rdPixel;
            wasIdle = !mBusy && !armed;
            mDone = 1'b0;
            if (armed) begin
                doneWait++;
                if (doneWait == 2) mBusy = 1'b0;  // final table write
                if (doneWait == 3) begin
                    mDone = 1'b1;
                    armed = 1'b0;
                end
            end
            if (mCollect && binValid) begin
                binCounts[binCnt] = binCount;
                binCnt++;
                if (binCnt == PixelNum * NBins) begin
                    mCollect = 1'b0;
                    armed = 1'b1;
                    doneWait = 0;
                    for (p = 0; p < PixelNum; p++) begin
                        expPeak[p] = findPeak(p);
                        setBounds(p);
                    end
                end
            end else if (wasIdle && frameStart) begin
                mCollect = 1'b1;
                mBusy = 1'b1;
                binCnt = 0;
            end
        end
    end

endmodule

`default_nettype wire

//--- hdl/sifhTop.sv
`timescale 1ns/10ps
`default_nettype none

module sifhTop #(
    parameter int Nb = sifhPkg::NbDefault,
    parameter int Np = sifhPkg::NpDefault,
    parameter int Nc = sifhPkg::NcDefault,
    parameter int PixelNum = sifhPkg::PixelNumDefault,
    localparam int Pw = (PixelNum > 1) ? $clog2(PixelNum) : 1
) (
    input  wire           clk,
    input  wire           res,
    input  wire           frameStart,
    input  wire           binValid,
    input  wire  [Nc-1:0] binCount,
    input  wire  [Pw-1:0] rdPixel,
    output logic          busy,
    output logic          frameDone,
    output logic [Nb-1:0] rdPeak,
    output logic [Np-1:0] rdThMinus,
    output logic [Np-1:0] rdThPlus,
    output logic [Np-1:0] rdCenter
);

    logic          collecting;
    logic          lastBin;
    logic          lastPixel;
    logic [Nb-1:0] binIdx;
    logic [Pw-1:0] pixelIdx;
    logic          wrEn;
    logic [Pw-1:0] wrPixel;
    logic [Nb-1:0] wrPeak;
    logic [Np-1:0] wrThMinus;
    logic [Np-1:0] wrThPlus;
    logic [Np-1:0] wrCenter;

    peakIf #(.Nb(Nb), .Nc(Nc), .PixelNum(PixelNum)) peak0 ();

    frameControl frameCtl0 (
        .clk(clk), .res(res), .frameStart(frameStart), .lastBin(lastBin),
        .lastPixel(lastPixel), .binValid(binValid), .wrEn(wrEn),
        .collecting(collecting), .busy(busy), .frameDone(frameDone)
    );

    pixelCounter #(.Nb(Nb), .PixelNum(PixelNum)) pixelCnt0 (
        .clk(clk), .res(res), .collecting(collecting), .binValid(binValid),
        .binIdx(binIdx), .pixelIdx(pixelIdx), .lastBin(lastBin), .lastPixel(lastPixel)
    );

    peakSearch #(.Nb(Nb), .Nc(Nc), .PixelNum(PixelNum)) peakSearch0 (
        .clk(clk), .res(res), .collecting(collecting), .binValid(binValid),
        .binCount(binCount), .binIdx(binIdx), .pixelIdx(pixelIdx), .lastBin(lastBin),
        .peak(peak0.src)
    );

    thresholdCalc #(.Nb(Nb), .Np(Np), .Nc(Nc), .PixelNum(PixelNum)) thCalc0 (
        .clk(clk), .res(res), .peak(peak0.dst), .wrEn(wrEn), .wrPixel(wrPixel),
        .wrPeak(wrPeak), .wrThMinus(wrThMinus), .wrThPlus(wrThPlus), .wrCenter(wrCenter)
    );

    thresholdTable #(.Nb(Nb), .Np(Np), .PixelNum(PixelNum)) thTable0 (
        .clk(clk), .res(res), .wrEn(wrEn), .wrPixel(wrPixel), .wrPeak(wrPeak),
        .wrThMinus(wrThMinus), .wrThPlus(wrThPlus), .wrCenter(wrCenter),
        .rdPixel(rdPixel), .rdPeak(rdPeak), .rdThMinus(rdThMinus),
        .rdThPlus(rdThPlus), .rdCenter(rdCenter)
    );

endmodule

`default_nettype wire

//--- hdl/thresholdTable.sv
`timescale 1ns/10ps
`default_nettype none

module thresholdTable #(
    parameter int Nb = sifhPkg::NbDefault,
    parameter int Np = sifhPkg::NpDefault,
    parameter int PixelNum = sifhPkg::PixelNumDefault,
    localparam int Pw = (PixelNum > 1) ? $clog2(PixelNum) : 1
) (
    input  wire           clk,
    input  wire           res,
    input  wire           wrEn,
    input  wire  [Pw-1:0] wrPixel,
    input  wire  [Nb-1:0] wrPeak,
    input  wire  [Np-1:0] wrThMinus,
    input  wire  [Np-1:0] wrThPlus,
    input  wire  [Np-1:0] wrCenter,
    input  wire  [Pw-1:0] rdPixel,
    output logic [Nb-1:0] rdPeak,
    output logic [Np-1:0] rdThMinus,
    output logic [Np-1:0] rdThPlus,
    output logic [Np-1:0] rdCenter
);

    logic [Nb-1:0] peakMem    [PixelNum];
    logic [Np-1:0] thMinusMem [PixelNum];
    logic [Np-1:0] thPlusMem  [PixelNum];
    logic [Np-1:0] centerMem  [PixelNum];

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            for (int i = 0; i < PixelNum; i++) begin
                peakMem[i]    <= '0; // all pixels read zero after reset
                thMinusMem[i] <= '0;
                thPlusMem[i]  <= '0;
                centerMem[i]  <= '0;
            end
            rdPeak    <= '0;
            rdThMinus <= '0;
            rdThPlus  <= '0;
            rdCenter  <= '0;
        end else begin
            if (wrEn) begin
                peakMem[wrPixel]    <= wrPeak;
                thMinusMem[wrPixel] <= wrThMinus;
                thPlusMem[wrPixel]  <= wrThPlus;
                centerMem[wrPixel]  <= wrCenter;
            end
            rdPeak    <= peakMem[rdPixel]; // one cycle read latency
            rdThMinus <= thMinusMem[rdPixel];
            rdThPlus  <= thPlusMem[rdPixel];
            rdCenter  <= centerMem[rdPixel];
        end
    end

endmodule

`default_nettype wire

//--- hdl/thresholdCalc.sv
`timescale 1ns/10ps
`default_nettype none

module thresholdCalc #(
    parameter int Nb = sifhPkg::NbDefault,
    parameter int Np = sifhPkg::NpDefault,
    parameter int Nc = sifhPkg::NcDefault,
    parameter int PixelNum = sifhPkg::PixelNumDefault,
    localparam int Pw = (PixelNum > 1) ? $clog2(PixelNum) : 1
) (
    input  wire           clk,
    input  wire           res,
    peakIf.dst            peak,
    output logic          wrEn,
    output logic [Pw-1:0] wrPixel,
    output logic [Nb-1:0] wrPeak,
    output logic [Np-1:0] wrThMinus,
    output logic [Np-1:0] wrThPlus,
    output logic [Np-1:0] wrCenter
);

    localparam int Sh = Np - Nb; // log2 of the bin width

    // half window of one and a half bins
    localparam logic [Np-1:0] Sb = Np'(3) << (Sh - 1);
    localparam logic [Np-1:0] FullScale = '1;

    logic [Np-1:0] ch;
    logic [Np-1:0] thMinus;
    logic [Np-1:0] thPlus;
    logic [Np:0]   boundSum;

    assign ch = {peak.bin, {Sh{1'b0}}}; // scaled peak

    always_comb begin
        if (ch >= FullScale - Sb) begin
            thPlus  = FullScale; // window pinned at the top
            thMinus = FullScale - (Sb << 1);
        end else if (ch <= Sb) begin
            thMinus = '0; // pinned at zero
            thPlus  = Sb << 1;
        end else begin
            thPlus  = ch + Sb;
            thMinus = ch - Sb;
        end
    end

    assign boundSum = {1'b0, thMinus} + {1'b0, thPlus}; // one extra bit for the carry

    always_ff @(posedge clk) begin
        if (peak.valid) begin
            wrPixel   <= peak.pixel;
            wrPeak    <= peak.bin;
            wrThMinus <= thMinus;
            wrThPlus  <= thPlus;
            wrCenter  <= boundSum[Np:1];
        end
    end

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            wrEn <= 1'b0;
        end else begin
            wrEn <= peak.valid; // results line up with wrEn
        end
    end

endmodule

`default_nettype wire

//--- hdl/peakSearch.sv
`timescale 1ns/10ps
`default_nettype none

module peakSearch #(
    parameter int Nb = sifhPkg::NbDefault,
    parameter int Nc = sifhPkg::NcDefault,
    parameter int PixelNum = sifhPkg::PixelNumDefault,
    localparam int Pw = (PixelNum > 1) ? $clog2(PixelNum) : 1
) (
    input  wire          clk,
    input  wire          res,
    input  wire          collecting,
    input  wire          binValid,
    input  wire [Nc-1:0] binCount,
    input  wire [Nb-1:0] binIdx,
    input  wire [Pw-1:0] pixelIdx,
    input  wire          lastBin,
    peakIf.src           peak
);

    logic          accept;
    logic          take;
    logic [Nc-1:0] bestCount;
    logic [Nb-1:0] bestBin;
    logic [Nc-1:0] newCount;
    logic [Nb-1:0] newBin;

    assign accept = collecting & binValid;

    // strictly greater, so the earlier bin keeps a tie
    assign take     = (binIdx == '0) || (binCount > bestCount);
    assign newCount = take ? binCount : bestCount;
    assign newBin   = take ? binIdx : bestBin;

    always_ff @(posedge clk) begin
        if (accept) begin
            bestCount <= newCount;
            bestBin   <= newBin;
        end
        if (accept && lastBin) begin
            // publish including the last bin itself
            peak.bin   <= newBin;
            peak.count <= newCount;
            peak.pixel <= pixelIdx;
        end
    end

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            peak.valid <= 1'b0;
        end else begin
            peak.valid <= accept & lastBin; // one pulse per pixel
        end
    end

endmodule

`default_nettype wire

//--- hdl/pixelCounter.sv
`timescale 1ns/10ps
`default_nettype none

module pixelCounter #(
    parameter int Nb = sifhPkg::NbDefault,
    parameter int PixelNum = sifhPkg::PixelNumDefault,
    localparam int Pw = (PixelNum > 1) ? $clog2(PixelNum) : 1
) (
    input  wire           clk,
    input  wire           res,
    input  wire           collecting,
    input  wire           binValid,
    output logic [Nb-1:0] binIdx,
    output logic [Pw-1:0] pixelIdx,
    output logic          lastBin,
    output logic          lastPixel
);

    assign lastBin   = (binIdx == '1);
    assign lastPixel = (pixelIdx == Pw'(PixelNum - 1));

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            binIdx   <= '0;
            pixelIdx <= '0;
        end else if (!collecting) begin
            binIdx   <= '0; // next frame starts at pixel 0, bin 0
            pixelIdx <= '0;
        end else if (binValid) begin
            binIdx <= binIdx + 1'b1; // wraps at the end of a pixel
            if (lastBin) begin
                pixelIdx <= lastPixel ? '0 : pixelIdx + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- hdl/frameControl.sv
`timescale 1ns/10ps
`default_nettype none

module frameControl (
    input  wire  clk,
    input  wire  res,
    input  wire  frameStart,
    input  wire  lastBin,
    input  wire  lastPixel,
    input  wire  binValid,
    input  wire  wrEn,
    output logic collecting,
    output logic busy,
    output logic frameDone
);

    sifhPkg::frameState_e state;
    sifhPkg::frameState_e stateNext;

    logic finalBin;

    assign finalBin = binValid & lastBin & lastPixel; // last bin of last pixel

    always_comb begin
        stateNext = state;
        case (state)
            sifhPkg::stIdle:    if (frameStart) stateNext = sifhPkg::stCollect;
            sifhPkg::stCollect: if (finalBin)   stateNext = sifhPkg::stDrain;
            sifhPkg::stDrain:   if (wrEn)       stateNext = sifhPkg::stDone;
            default:                            stateNext = sifhPkg::stIdle;
        endcase
    end

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            state     <= sifhPkg::stIdle;
            frameDone <= 1'b0;
        end else begin
            state     <= stateNext;
            frameDone <= (state == sifhPkg::stDone); // single pulse, back to idle
        end
    end

    assign collecting = (state == sifhPkg::stCollect);
    assign busy       = (state == sifhPkg::stCollect) || (state == sifhPkg::stDrain);

endmodule

`default_nettype wire

//--- hdl/peakIf.sv
`timescale 1ns/10ps
`default_nettype none

interface peakIf #(
    parameter int Nb = sifhPkg::NbDefault,
    parameter int Nc = sifhPkg::NcDefault,
    parameter int PixelNum = sifhPkg::PixelNumDefault,
    localparam int Pw = (PixelNum > 1) ? $clog2(PixelNum) : 1
);

    logic          valid; // one-cycle pulse per pixel
    logic [Nb-1:0] bin;   // winning bin
    logic [Nc-1:0] count; // count of the winning bin
    logic [Pw-1:0] pixel; // pixel the peak belongs to

    modport src (output valid, bin, count, pixel);
    modport dst (input valid, bin, count, pixel);

endinterface

`default_nettype wire

//--- hdl/sifhPkg.sv
`default_nettype none

package sifhPkg;

    // bin index width, a pixel has 2**Nb bins
    parameter int NbDefault = 4;

    // threshold width, must exceed Nb
    parameter int NpDefault = 8;

    parameter int NcDefault = 8;       // bin count width
    parameter int PixelNumDefault = 8; // pixels per frame

    // frame sequencing
    typedef enum logic [1:0] {
        stIdle    = 2'd0, // waiting for frameStart
        stCollect = 2'd1, // bins arriving
        stDrain   = 2'd2, // last pixel still in the pipeline
        stDone    = 2'd3  // final write seen
    } frameState_e;

endpackage

`default_nettype wire
